/* cpu_params_pkg.sv */
package cpu_params_pkg;

    // machine widths
    localparam int DATA_W   = 32;
    localparam int PHY_W    = 6;
    localparam int ROB_W    = 5;

    // one register per physical tag
    localparam int PHY_REGS = 2 ** PHY_W;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [PHY_W-1:0]  phy_reg_t;
    typedef logic [ROB_W-1:0]  rob_id_t;

endpackage

/* uop_types_pkg.sv */
package uop_types_pkg;

    localparam int IMM_W = 12;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

    typedef enum logic {
        OP2_REG = 1'b0,
        OP2_IMM = 1'b1
    } op2_sel_e;

    // renamed micro-op as sent by dispatch
    typedef struct packed {
        cpu_params_pkg::rob_id_t  rob_id;
        cpu_params_pkg::phy_reg_t rs1_phy;
        cpu_params_pkg::phy_reg_t rs2_phy;
        cpu_params_pkg::phy_reg_t rd_phy;
        alu_op_e                  op;
        op2_sel_e                 op2_sel;
        logic [IMM_W-1:0]         imm;
    } uop_t;

    typedef struct packed {
        uop_t uop;
        logic rs1_ready;
        logic rs2_ready;
    } rs_entry_t;

    // result bus, also the wakeup broadcast
    typedef struct packed {
        logic                     valid;
        cpu_params_pkg::rob_id_t  rob_id;
        cpu_params_pkg::phy_reg_t rd_phy;
        cpu_params_pkg::data_t    value;
    } cdb_t;

    typedef enum logic [1:0] {
        UPD_KEEP  = 2'd0,
        UPD_SHIFT = 2'd1,
        UPD_PUSH  = 2'd2
    } slot_update_e;

endpackage

/* rs_entry.sv */
`timescale 1ns/1ps

module rs_entry (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     load,
    input  logic                     clear,
    input  uop_types_pkg::rs_entry_t entry_in,
    input  uop_types_pkg::cdb_t      cdb,
    output logic                     valid,
    output logic                     request,
    output uop_types_pkg::rs_entry_t entry
);

    uop_types_pkg::rs_entry_t entry_next;

    // mark sources whose tag is on the result bus
    function automatic uop_types_pkg::rs_entry_t wake(
        input uop_types_pkg::rs_entry_t e,
        input uop_types_pkg::cdb_t      c
    );
        uop_types_pkg::rs_entry_t w;
        w = e;
        if (c.valid && (c.rd_phy == e.uop.rs1_phy)) begin
            w.rs1_ready = 1'b1;
        end
        if (c.valid && (c.rd_phy == e.uop.rs2_phy)) begin
            w.rs2_ready = 1'b1;
        end
        return w;
    endfunction

    // a shifted or pushed entry can wake in the same cycle
    always_comb begin
        if (load) begin
            entry_next = wake(entry_in, cdb);
        end else begin
            entry_next = wake(entry, cdb);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (clear) begin
            valid <= 1'b0;
        end else if (load) begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        entry <= entry_next;
    end

    assign request = valid & entry.rs1_ready & entry.rs2_ready;

endmodule

/* int_rs_control.sv */
`timescale 1ns/1ps

module int_rs_control #(
    parameter  int RS_DEPTH = 8,
    localparam int IDX_W    = $clog2(RS_DEPTH)
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    dispatch_valid,
    input  uop_types_pkg::rs_entry_t                dispatch_entry,
    input  logic [RS_DEPTH-1:0]                     slot_valid,
    input  uop_types_pkg::rs_entry_t [RS_DEPTH-1:0] slot_entries,
    input  logic                                    issue_en,
    input  logic [IDX_W-1:0]                        issue_idx,
    output logic [RS_DEPTH-1:0]                     slot_load,
    output logic [RS_DEPTH-1:0]                     slot_clear,
    output uop_types_pkg::rs_entry_t [RS_DEPTH-1:0] slot_entry_in,
    output logic                                    dispatch_ready,
    output logic                                    accept
);

    localparam int CNT_W = $clog2(RS_DEPTH + 1);

    logic [CNT_W-1:0]                        count;
    logic [CNT_W-1:0]                        count_popped;
    logic [CNT_W-1:0]                        count_next;
    logic [RS_DEPTH-1:0]                     upper_valid;
    uop_types_pkg::rs_entry_t [RS_DEPTH-1:0] upper_entries;
    uop_types_pkg::slot_update_e             slot_sel [RS_DEPTH];

    ////////////////////
    // occupancy
    ////////////////////

    assign dispatch_ready = (count != CNT_W'(RS_DEPTH));
    assign accept         = dispatch_valid & dispatch_ready;

    // push lands on the first free slot after this cycle's pop
    assign count_popped = count - CNT_W'(issue_en);
    assign count_next   = count_popped + CNT_W'(accept);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            count <= count_next;
        end
    end

    ////////////////////
    // compaction
    ////////////////////

    // source for a shift is always the upper neighbour, top slot has none
    assign upper_valid   = {1'b0, slot_valid[RS_DEPTH-1:1]};
    assign upper_entries = {uop_types_pkg::rs_entry_t'('0), slot_entries[RS_DEPTH-1:1]};

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (accept && (CNT_W'(i) == count_popped)) begin
                slot_sel[i] = uop_types_pkg::UPD_PUSH;
            end else if (issue_en && slot_valid[i] && (IDX_W'(i) >= issue_idx)) begin
                slot_sel[i] = uop_types_pkg::UPD_SHIFT;
            end else begin
                slot_sel[i] = uop_types_pkg::UPD_KEEP;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            slot_load[i]     = 1'b0;
            slot_clear[i]    = 1'b0;
            slot_entry_in[i] = upper_entries[i];
            case (slot_sel[i])
                uop_types_pkg::UPD_PUSH: begin
                    slot_load[i]     = 1'b1;
                    slot_entry_in[i] = dispatch_entry;
                end
                uop_types_pkg::UPD_SHIFT: begin
                    // empty neighbour means this slot drains
                    slot_load[i]  = upper_valid[i];
                    slot_clear[i] = ~upper_valid[i];
                end
                default: ;
            endcase
        end
    end

endmodule

/* issue_arbiter.sv */
`timescale 1ns/1ps

module issue_arbiter #(
    parameter  int RS_DEPTH = 8,
    localparam int IDX_W    = $clog2(RS_DEPTH)
) (
    input  logic [RS_DEPTH-1:0] request,
    output logic [RS_DEPTH-1:0] grant,
    output logic                issue_en,
    output logic [IDX_W-1:0]    issue_idx
);

    // lowest index is oldest, scan downward so it wins
    always_comb begin
        issue_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (request[i]) begin
                issue_idx = IDX_W'(i);
            end
        end
    end

    assign issue_en = |request;

    always_comb begin
        grant            = '0;
        grant[issue_idx] = issue_en;
    end

endmodule

/* phys_reg_file.sv */
`timescale 1ns/1ps

module phys_reg_file (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     accept,
    input  uop_types_pkg::uop_t      dispatch_uop,
    output logic [1:0]               src_ready,
    input  uop_types_pkg::rs_entry_t issue_entry,
    output cpu_params_pkg::data_t    rs1_value,
    output cpu_params_pkg::data_t    rs2_value,
    input  uop_types_pkg::cdb_t      cdb
);

    cpu_params_pkg::data_t               regs [cpu_params_pkg::PHY_REGS];
    logic [cpu_params_pkg::PHY_REGS-1:0] busy;
    logic                                rs1_hit;
    logic                                rs2_hit;

    ////////////////////
    // dispatch lookup
    ////////////////////

    // same-cycle broadcast counts as ready
    assign rs1_hit = cdb.valid && (cdb.rd_phy == dispatch_uop.rs1_phy);
    assign rs2_hit = cdb.valid && (cdb.rd_phy == dispatch_uop.rs2_phy);

    assign src_ready[0] = ~busy[dispatch_uop.rs1_phy] | rs1_hit;
    assign src_ready[1] = (dispatch_uop.op2_sel == uop_types_pkg::OP2_IMM)
                        | ~busy[dispatch_uop.rs2_phy] | rs2_hit;

    ////////////////////
    // update
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            // register p starts out holding p
            for (int p = 0; p < cpu_params_pkg::PHY_REGS; p++) begin
                regs[p] <= cpu_params_pkg::data_t'(p);
            end
            busy <= '0;
        end else begin
            if (cdb.valid) begin
                regs[cdb.rd_phy] <= cdb.value;
                busy[cdb.rd_phy] <= 1'b0;
            end
            // new destination goes busy
            if (accept) begin
                busy[dispatch_uop.rd_phy] <= 1'b1;
            end
        end
    end

    // issue read ports
    assign rs1_value = regs[issue_entry.uop.rs1_phy];
    assign rs2_value = regs[issue_entry.uop.rs2_phy];

endmodule

/* fu_alu.sv */
`timescale 1ns/1ps

module fu_alu (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     issue_en,
    input  uop_types_pkg::rs_entry_t issue_entry,
    input  cpu_params_pkg::data_t    rs1_value,
    input  cpu_params_pkg::data_t    rs2_value,
    output uop_types_pkg::cdb_t      cdb
);

    cpu_params_pkg::data_t op_b;
    cpu_params_pkg::data_t result;

    // second operand, immediate is sign extended
    always_comb begin
        if (issue_entry.uop.op2_sel == uop_types_pkg::OP2_IMM) begin
            op_b = cpu_params_pkg::data_t'($signed(issue_entry.uop.imm));
        end else begin
            op_b = rs2_value;
        end
    end

    always_comb begin
        case (issue_entry.uop.op)
            uop_types_pkg::ALU_ADD: result = rs1_value + op_b;
            uop_types_pkg::ALU_SUB: result = rs1_value - op_b;
            uop_types_pkg::ALU_AND: result = rs1_value & op_b;
            uop_types_pkg::ALU_OR:  result = rs1_value | op_b;
            uop_types_pkg::ALU_XOR: result = rs1_value ^ op_b;
            // shift amount from the low 5 bits
            uop_types_pkg::ALU_SLL: result = rs1_value << op_b[4:0];
            uop_types_pkg::ALU_SRL: result = rs1_value >> op_b[4:0];
            uop_types_pkg::ALU_SLT: begin
                result = cpu_params_pkg::data_t'($signed(rs1_value) < $signed(op_b));
            end
            default: result = '0;
        endcase
    end

    // result goes out on the bus one cycle after issue
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= issue_en;
        end
        cdb.rob_id <= issue_entry.uop.rob_id;
        cdb.rd_phy <= issue_entry.uop.rd_phy;
        cdb.value  <= result;
    end

endmodule

/* int_rs_ordered.sv */
`timescale 1ns/1ps

module int_rs_ordered #(
    parameter int RS_DEPTH = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                dispatch_valid,
    input  uop_types_pkg::uop_t dispatch_uop,
    output logic                dispatch_ready,
    output uop_types_pkg::cdb_t cdb
);

    localparam int IDX_W = $clog2(RS_DEPTH);

    logic [RS_DEPTH-1:0]                     slot_valid;
    logic [RS_DEPTH-1:0]                     slot_request;
    logic [RS_DEPTH-1:0]                     slot_load;
    logic [RS_DEPTH-1:0]                     slot_clear;
    logic [RS_DEPTH-1:0]                     grant;
    uop_types_pkg::rs_entry_t [RS_DEPTH-1:0] slot_entries;
    uop_types_pkg::rs_entry_t [RS_DEPTH-1:0] slot_entry_in;
    uop_types_pkg::rs_entry_t [RS_DEPTH:0]   pick_chain;
    uop_types_pkg::rs_entry_t                dispatch_entry;
    uop_types_pkg::rs_entry_t                issue_entry;
    logic [1:0]                              src_ready;
    logic                                    accept;
    logic                                    issue_en;
    logic [IDX_W-1:0]                        issue_idx;
    cpu_params_pkg::data_t                   rs1_value;
    cpu_params_pkg::data_t                   rs2_value;

    // dispatch uop plus source readiness from the register file
    assign dispatch_entry = '{
        uop:       dispatch_uop,
        rs1_ready: src_ready[0],
        rs2_ready: src_ready[1]
    };

    ////////////////////
    // station slots
    ////////////////////

    for (genvar i = 0; i < RS_DEPTH; i++) begin : g_slot
        rs_entry u_slot (
            .clk      (clk),
            .rst      (rst),
            .load     (slot_load[i]),
            .clear    (slot_clear[i]),
            .entry_in (slot_entry_in[i]),
            .cdb      (cdb),
            .valid    (slot_valid[i]),
            .request  (slot_request[i]),
            .entry    (slot_entries[i])
        );

        // one-hot pick of the granted slot
        assign pick_chain[i+1] = pick_chain[i] | (grant[i] ? slot_entries[i] : '0);
    end

    assign pick_chain[0] = '0;
    assign issue_entry   = pick_chain[RS_DEPTH];

    int_rs_control #(
        .RS_DEPTH (RS_DEPTH)
    ) u_control (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_entry (dispatch_entry),
        .slot_valid     (slot_valid),
        .slot_entries   (slot_entries),
        .issue_en       (issue_en),
        .issue_idx      (issue_idx),
        .slot_load      (slot_load),
        .slot_clear     (slot_clear),
        .slot_entry_in  (slot_entry_in),
        .dispatch_ready (dispatch_ready),
        .accept         (accept)
    );

    issue_arbiter #(
        .RS_DEPTH (RS_DEPTH)
    ) u_arbiter (
        .request   (slot_request),
        .grant     (grant),
        .issue_en  (issue_en),
        .issue_idx (issue_idx)
    );

    ////////////////////
    // execute
    ////////////////////

    phys_reg_file u_prf (
        .clk          (clk),
        .rst          (rst),
        .accept       (accept),
        .dispatch_uop (dispatch_uop),
        .src_ready    (src_ready),
        .issue_entry  (issue_entry),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .cdb          (cdb)
    );

    fu_alu u_alu (
        .clk         (clk),
        .rst         (rst),
        .issue_en    (issue_en),
        .issue_entry (issue_entry),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .cdb         (cdb)
    );

endmodule

/* tb_int_rs.sv */
`timescale 1ns/1ps

module tb_int_rs;

    localparam int RS_DEPTH   = 8;
    localparam int NUM_UOPS   = 24;
    localparam int NUM_COLS   = 9;
    localparam int MAX_CYCLES = 20 * NUM_UOPS + 100;

    // test slots
    localparam int T_RESET   = 0;
    localparam int T_ONCE    = 1;
    localparam int T_ORDER   = 2;
    localparam int T_CHAIN   = 3;
    localparam int T_FULL    = 4;
    localparam int NUM_TESTS = 5;

    logic                clk;
    logic                rst;
    logic                dispatch_valid;
    uop_types_pkg::uop_t dispatch_uop;
    logic                dispatch_ready;
    uop_types_pkg::cdb_t cdb;

    // row layout is group rob_id rs1 rs2 rd op op2_sel imm expected
    logic [31:0] stim [NUM_UOPS*NUM_COLS];
    int          seen [NUM_UOPS];
    int          checks [NUM_TESTS];
    int          errors [NUM_TESTS];
    string       test_names [NUM_TESTS];
    int          send_order [$];
    int          next_ordered;
    int          results = 0;
    int          cycles = 0;
    logic        ready_dropped;

    int_rs_ordered #(
        .RS_DEPTH (RS_DEPTH)
    ) dut0 (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_uop   (dispatch_uop),
        .dispatch_ready (dispatch_ready),
        .cdb            (cdb)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] stim_word(input int n, input int col);
        return stim[n*NUM_COLS+col];
    endfunction

    // which test owns the results of a group
    function automatic int group_test(input logic [31:0] grp);
        case (grp)
            32'd1:   return T_ORDER;
            32'd2:   return T_CHAIN;
            default: return T_FULL;
        endcase
    endfunction

    // first uop of the given group after index n
    function automatic int next_in_group(input int n, input logic [31:0] grp);
        for (int i = n + 1; i < NUM_UOPS; i++) begin
            if (stim_word(i, 0) == grp) begin
                return i;
            end
        end
        return NUM_UOPS;
    endfunction

    task automatic drive_uop(input int n);
        dispatch_uop.rob_id  = stim[n*NUM_COLS+1][4:0];
        dispatch_uop.rs1_phy = stim[n*NUM_COLS+2][5:0];
        dispatch_uop.rs2_phy = stim[n*NUM_COLS+3][5:0];
        dispatch_uop.rd_phy  = stim[n*NUM_COLS+4][5:0];
        dispatch_uop.op      = uop_types_pkg::alu_op_e'(stim[n*NUM_COLS+5][2:0]);
        dispatch_uop.op2_sel = uop_types_pkg::op2_sel_e'(stim[n*NUM_COLS+6][0]);
        dispatch_uop.imm     = stim[n*NUM_COLS+7][11:0];
    endtask

    task automatic report_test(input int t);
        if (errors[t] == 0) begin
            $display("test %-16s ok, %0d checks", test_names[t], checks[t]);
        end else begin
            $display("test %-16s failed, %0d of %0d checks", test_names[t], errors[t],
                     checks[t]);
        end
    endtask

    // one result on the bus, compared with the file
    task automatic check_result();
        int               rob;
        int               t;
        logic [31:0]      grp;
        logic [31:0]      exp_value;
        logic [5:0]       exp_rd;
        rob = int'(cdb.rob_id);
        checks[T_ONCE]++;
        assert (rob < NUM_UOPS) else begin
            $display("result at %0t carries rob_id %0d, which was never sent", $time, rob);
            errors[T_ONCE]++;
        end
        if (rob < NUM_UOPS) begin
            grp       = stim_word(rob, 0);
            exp_rd    = stim[rob*NUM_COLS+4][5:0];
            exp_value = stim_word(rob, 8);
            t         = group_test(grp);
            seen[rob]++;
            if (seen[rob] == 1) begin
                results++;
            end
            checks[t] += 2;
            assert (cdb.rd_phy == exp_rd) else begin
                $display("Error at %0t: cdb.rd_phy for rob_id %0d expected %h got %h",
                         $time, rob, exp_rd, cdb.rd_phy);
                errors[t]++;
            end
            assert (cdb.value == exp_value) else begin
                $display("Error at %0t: cdb.value for rob_id %0d expected %h got %h",
                         $time, rob, exp_value, cdb.value);
                errors[t]++;
            end
            // independent uops leave in dispatch order
            if (grp == 32'd1) begin
                checks[T_ORDER]++;
                assert (rob == next_ordered) else begin
                    $display("Error at %0t: cdb.rob_id expected %0d got %0d",
                             $time, next_ordered, rob);
                    errors[T_ORDER]++;
                end
                next_ordered = next_in_group(rob, 32'd1);
            end
        end
    endtask

    ////////////////////
    // result monitor
    ////////////////////

    initial begin
        forever begin
            @(negedge clk);
            if (!rst && cdb.valid) begin
                check_result();
            end
        end
    end

    // watchdog
    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles without finishing", cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        int   n;
        int   total_checks;
        int   total_errors;
        logic accepted;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_uop   = '0;
        ready_dropped  = 1'b0;
        test_names     = '{"reset_state", "exactly_once", "issue_order",
                           "dependency_chain", "back_pressure"};
        for (int i = 0; i < NUM_TESTS; i++) begin
            checks[i] = 0;
            errors[i] = 0;
        end
        for (int i = 0; i < NUM_UOPS; i++) begin
            seen[i] = 0;
        end
        $readmemh("int_rs_input.txt", stim);
        next_ordered = next_in_group(-1, 32'd1);

        // independent group goes last and queues up behind chain wakeups
        for (int i = 0; i < NUM_UOPS; i++) begin
            if (stim_word(i, 0) != 32'd1) begin
                send_order.push_back(i);
            end
        end
        for (int i = 0; i < NUM_UOPS; i++) begin
            if (stim_word(i, 0) == 32'd1) begin
                send_order.push_back(i);
            end
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        checks[T_RESET] += 2;
        assert (cdb.valid == 1'b0) else begin
            $display("Error at %0t: cdb.valid expected 0 got %b", $time, cdb.valid);
            errors[T_RESET]++;
        end
        assert (dispatch_ready == 1'b1) else begin
            $display("Error at %0t: dispatch_ready expected 1 got %b", $time, dispatch_ready);
            errors[T_RESET]++;
        end
        report_test(T_RESET);

        // ready follows the occupancy count only
        n = 0;
        while (n < NUM_UOPS) begin
            drive_uop(send_order[n]);
            dispatch_valid = 1'b1;
            accepted       = dispatch_ready;
            if (!accepted) begin
                ready_dropped = 1'b1;
            end
            @(negedge clk);
            if (accepted) begin
                n++;
            end
        end
        dispatch_valid = 1'b0;

        while (results < NUM_UOPS) begin
            @(negedge clk);
        end
        // late duplicates
        repeat (10) @(negedge clk);

        report_test(T_ORDER);
        report_test(T_CHAIN);

        checks[T_FULL]++;
        assert (ready_dropped) else begin
            $display("dispatch_ready never went low while the burst was sent");
            errors[T_FULL]++;
        end
        report_test(T_FULL);

        for (int i = 0; i < NUM_UOPS; i++) begin
            checks[T_ONCE]++;
            assert (seen[i] == 1) else begin
                if (seen[i] == 0) begin
                    $display("rob_id %0d never produced a result", i);
                end else begin
                    $display("rob_id %0d produced %0d results instead of one", i, seen[i]);
                end
                errors[T_ONCE]++;
            end
        end
        report_test(T_ONCE);

        total_checks = 0;
        total_errors = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            total_checks += checks[i];
            total_errors += errors[i];
        end
        $display("%0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* int_rs_input.txt */
// group rob_id rs1 rs2 rd op op2_sel imm expected, all hex
// group 1 independent, 2 chain over all ops, 3 chained burst
1 00 05 07 20 0 0 000 0000000c
1 01 14 00 21 1 1 003 00000011
1 02 09 06 22 4 0 000 0000000f
1 03 10 00 23 3 1 00f 0000001f
2 04 0a 00 24 0 1 005 0000000f
2 05 24 02 25 5 0 000 0000003c
2 06 25 24 26 1 0 000 0000002d
2 07 26 25 27 2 0 000 0000002c
2 08 27 00 28 3 1 100 0000012c
2 09 28 00 29 4 1 fff fffffed3
2 0a 29 04 2a 6 0 000 0fffffed
2 0b 29 2a 2b 7 0 000 00000001
3 0c 2b 00 2c 0 1 002 00000003
3 0d 2c 2c 2d 0 0 000 00000006
3 0e 2d 00 2e 0 1 001 00000007
3 0f 2e 00 2f 5 1 001 0000000e
3 10 2f 00 30 1 1 004 0000000a
3 11 30 2e 31 4 0 000 0000000d
3 12 31 00 32 0 1 010 0000001d
3 13 32 2f 33 3 0 000 0000001f
3 14 33 00 34 6 1 001 0000000f
3 15 34 2d 35 2 0 000 00000006
3 16 35 00 36 7 1 007 00000001
3 17 36 31 37 1 0 000 fffffff4

/* all.f */
cpu_params_pkg.sv
uop_types_pkg.sv
rs_entry.sv
int_rs_control.sv
issue_arbiter.sv
phys_reg_file.sv
fu_alu.sv
int_rs_ordered.sv
tb_int_rs.sv

/* Makefile */
all: run

run:
	verilator --binary --timing --assert --top-module tb_int_rs -f all.f -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_int_rs)"; echo "$$out"; \
	echo "$$out" | grep -q '^STATUS: PASS$$'

lint:
	verilator --lint-only --timing --assert --top-module tb_int_rs -f all.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
